// ==== filelist.f ====
rtl/trace_cfg_pkg.sv
rtl/trace_types_pkg.sv
rtl/trace_capture.sv
rtl/trace_fifo.sv
rtl/trace_serializer.sv
rtl/pipe_trace_top.sv
tests/pipe_trace_assertions.sv
tests/pipe_trace_checker.sv
tests/pipe_trace_tb.sv

// ==== Makefile ====
# Verilator build and run for the pipeline trace unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= pipe_trace_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# Build, run, and pass only when the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/pipe_trace_tb.sv ====
// Trace unit testbench with clock, reset, LFSR stimulus, reference model and test sequence
`timescale 1ns/1ps

module pipe_trace_tb;

  logic                             clk;
  logic                             rst_n;
  logic                             issue;
  logic                             stall;
  logic                             out_ready;
  logic                             out_valid;
  logic [trace_cfg_pkg::data_w-1:0] issue_pc;
  logic [trace_cfg_pkg::data_w-1:0] issue_instr;
  logic [trace_cfg_pkg::data_w-1:0] ex_result;
  logic [trace_cfg_pkg::data_w-1:0] mem_addr;
  logic [trace_cfg_pkg::data_w-1:0] wb_value;
  logic [trace_cfg_pkg::data_w-1:0] out_word;
  logic [trace_cfg_pkg::drop_w-1:0] dropped_count;

  logic [31:0] lfsr = 32'h9842;
  int          issue_mode = 0;   // 0 off, 1 sparse, 2 dense
  logic        stall_on   = 1'b0;
  int          ready_mode = 0;   // 0 always, 1 random, 2 held low
  int          tests_run    = 0;
  int          tests_failed = 0;

  // Reference pipeline indexed by stage position
  logic                            model_valid [5];
  trace_types_pkg::trace_rec_t     model_rec   [5];
  logic [trace_cfg_pkg::seq_w-1:0] model_seq;
  int                              retire_cnt = 0;

  pipe_trace_top dut_i (
    .clk, .rst_n, .issue, .issue_pc, .issue_instr, .stall,
    .ex_result, .mem_addr, .wb_value, .out_ready, .out_valid, .out_word, .dropped_count
  );

  pipe_trace_checker checker_i (.clk, .rst_n, .out_valid, .out_ready, .out_word);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic pick_issue();
    case (issue_mode)
      0:       return 1'b0;
      1:       return rand_bits(4) == 32'd0;   // About one in sixteen
      default: return rand_bits(2) != 32'd0;   // About three in four
    endcase
  endfunction

  function automatic logic pick_ready();
    case (ready_mode)
      0:       return 1'b1;
      1:       return rand_bits(1) != 32'd0;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic pipe_busy();
    logic busy;
    busy = 1'b0;
    for (int i = 0; i < 5; i++)
      busy = busy | model_valid[i];
    return busy;
  endfunction

  ////////////////////////////////////////
  // Reference model, one step per edge
  ////////////////////////////////////////
  task automatic step_model();
    trace_types_pkg::trace_rec_t r;
    if (model_valid[4]) begin
      r          = model_rec[4];
      r.wb_value = wb_value;            // Write-back ends on this edge
      checker_i.add_expected(r);
      retire_cnt++;
    end
    model_valid[4]          = model_valid[3];
    model_rec[4]            = model_rec[3];
    model_rec[4].mem_addr   = mem_addr;
    model_valid[3]          = model_valid[2];
    model_rec[3]            = model_rec[2];
    model_rec[3].ex_result  = ex_result;
    if (stall) begin
      model_valid[2] = 1'b0;            // Bubble behind held decode
      for (int i = 0; i < 2; i++) begin
        if (model_valid[i] && model_rec[i].stall_cycles != '1)
          model_rec[i].stall_cycles = model_rec[i].stall_cycles + 8'd1;
      end
    end else begin
      model_valid[2] = model_valid[1];
      model_rec[2]   = model_rec[1];
      model_valid[1] = model_valid[0];
      model_rec[1]   = model_rec[0];
      model_valid[0] = issue;
      if (issue) begin
        model_rec[0] = '{seq: model_seq, pc: issue_pc, instr: issue_instr, default: '0};
        model_seq    = model_seq + 8'd1;
      end
    end
  endtask

  // Model reads the values applied before this edge and new inputs go out after it
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 5; i++)
        model_valid[i] = 1'b0;
      model_seq = '0;
    end else begin
      step_model();
    end
    issue       <= pick_issue();
    stall       <= stall_on && (rand_bits(2) == 32'd0);
    out_ready   <= pick_ready();
    issue_pc    <= rand_bits(32);
    issue_instr <= rand_bits(32);
    ex_result   <= rand_bits(32);
    mem_addr    <= rand_bits(32);
    wb_value    <= rand_bits(32);
  end

  ////////////////////////////////////////
  // Sequencing helpers
  ////////////////////////////////////////
  // Idle means model empty and no word on offer for a few cycles
  task automatic wait_idle();
    int n;
    int quiet;
    n     = 0;
    quiet = 0;
    while (quiet < 4 && n < 3000) begin
      @(negedge clk);
      n++;
      quiet = (pipe_busy() || out_valid) ? 0 : quiet + 1;
    end
    if (quiet < 4)
      checker_i.report_failure("timeout waiting for the trace stream to go idle");
    checker_i.flush_drops();
  endtask

  task automatic wait_pipe_empty();
    int n;
    n = 0;
    while (pipe_busy() && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (pipe_busy())
      checker_i.report_failure("timeout waiting for the pipeline to empty");
  endtask

  task automatic run_traffic(input int cycles, input int imode, input logic stalls,
                             input int rmode);
    issue_mode = imode;
    stall_on   = stalls;
    ready_mode = rmode;
    repeat (cycles) @(negedge clk);
    issue_mode = 0;
    stall_on   = 1'b0;
    ready_mode = 0;
    wait_idle();
  endtask

  task automatic check_drops();
    checker_i.compare_field("dropped_count", 32'(dropped_count), 32'(checker_i.drop_cnt));
  endtask

  task automatic end_test(input string name, input int errs_before);
    int errs;
    errs = checker_i.err_cnt - errs_before;
    tests_run++;
    if (errs != 0)
      tests_failed++;
    $display("Test %0d %s: %s, %0d errors", tests_run, name, (errs == 0) ? "ok" : "bad", errs);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    int errs_before;
    int drop_before;
    int ret_before;
    int survivors;
    rst_n       = 1'b0;
    issue       = 1'b0;
    stall       = 1'b0;
    out_ready   = 1'b0;
    issue_pc    = '0;
    issue_instr = '0;
    ex_result   = '0;
    mem_addr    = '0;
    wb_value    = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    errs_before = checker_i.err_cnt;   // State out of reset and a first record with seq 0
    checker_i.compare_field("out_valid", 32'(out_valid), 32'd0);
    checker_i.compare_field("dropped_count", 32'(dropped_count), 32'd0);
    run_traffic(200, 1, 1'b0, 0);
    if (checker_i.rec_cnt == 0)
      checker_i.report_failure("no record arrived after reset");
    else
      checker_i.compare_field("first_seq", 32'(checker_i.first_seq), 32'd0);
    check_drops();
    end_test("reset_state", errs_before);

    errs_before = checker_i.err_cnt;
    drop_before = int'(dropped_count);
    run_traffic(600, 1, 1'b0, 0);
    checker_i.compare_field("records_lost", 32'(int'(dropped_count) - drop_before), 32'd0);
    check_drops();
    end_test("no_stall", errs_before);

    errs_before = checker_i.err_cnt;
    run_traffic(600, 1, 1'b1, 0);
    check_drops();
    end_test("random_stall", errs_before);

    errs_before = checker_i.err_cnt;
    run_traffic(600, 1, 1'b0, 1);
    check_drops();
    end_test("random_ready", errs_before);

    errs_before = checker_i.err_cnt;   // Dense retirements against a stopped receiver
    ret_before  = retire_cnt;
    drop_before = int'(dropped_count);
    issue_mode  = 2;
    ready_mode  = 2;
    repeat (40) @(negedge clk);
    issue_mode  = 0;
    wait_pipe_empty();
    survivors = (retire_cnt - ret_before) - (int'(dropped_count) - drop_before);
    if (survivors > trace_cfg_pkg::fifo_depth + 1)  // Buffer plus the serializer's record
      checker_i.report_failure($sformatf("%0d records survived the hold", survivors));
    if (int'(dropped_count) == drop_before)
      checker_i.report_failure("no record was dropped while out_ready was held low");
    ready_mode = 0;
    run_traffic(300, 1, 1'b0, 0);
    check_drops();
    end_test("hold_drop", errs_before);

    $display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures, %0d records, %0d dropped",
             tests_run, tests_failed, checker_i.err_cnt, dut_i.assert_i.fail_cnt,
             checker_i.rec_cnt, checker_i.drop_cnt);
    if (tests_failed == 0 && checker_i.err_cnt == 0 && dut_i.assert_i.fail_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== tests/pipe_trace_checker.sv ====
// Checker that rebuilds trace records from output words and compares them with the model
`timescale 1ns/1ps

module pipe_trace_checker (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             out_valid,
  input logic                             out_ready,
  input logic [trace_cfg_pkg::data_w-1:0] out_word
);

  trace_types_pkg::trace_rec_t      exp_q [$];   // Model retirements with the oldest first
  logic [trace_cfg_pkg::data_w-1:0] words [trace_cfg_pkg::words_per_rec];
  int                               word_idx = 0;
  int                               err_cnt  = 0;
  int                               rec_cnt  = 0;  // Records received
  int                               drop_cnt = 0;  // Expected records never seen
  logic [trace_cfg_pkg::seq_w-1:0]  first_seq = '0;

  task automatic add_expected(input trace_types_pkg::trace_rec_t r);
    exp_q.push_back(r);
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic compare_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got 0x%h expected 0x%h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // Anything left once the DUT is idle was lost for lack of credit
  task automatic flush_drops();
    drop_cnt += exp_q.size();
    exp_q.delete();
  endtask

  ////////////////////////////////////////
  // Record assembly and compare
  ////////////////////////////////////////
  task automatic match_record();
    trace_types_pkg::trace_rec_t got;
    trace_types_pkg::trace_rec_t exp;
    logic                        found;
    got.pc           = words[0];
    got.instr        = words[1];
    got.ex_result    = words[2];
    got.mem_addr     = words[3];
    got.wb_value     = words[4];
    got.seq          = words[5][trace_cfg_pkg::seq_w-1:0];
    got.stall_cycles = words[5][trace_cfg_pkg::seq_w +: trace_cfg_pkg::stall_w];
    if (rec_cnt == 0)
      first_seq = got.seq;
    rec_cnt++;
    found = 1'b0;
    while (!found && exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      if (exp.seq == got.seq)
        found = 1'b1;
      else
        drop_cnt++;                   // Skipped over and counted as dropped
    end
    if (!found) begin
      report_failure($sformatf("record with seq %0d matches no expected record", got.seq));
    end else begin
      compare_field("pc", got.pc, exp.pc);
      compare_field("instr", got.instr, exp.instr);
      compare_field("ex_result", got.ex_result, exp.ex_result);
      compare_field("mem_addr", got.mem_addr, exp.mem_addr);
      compare_field("wb_value", got.wb_value, exp.wb_value);
      compare_field("stall_cycles", 32'(got.stall_cycles), 32'(exp.stall_cycles));
    end
    compare_field("word5_upper", words[5] >> 16, 32'd0);  // Reserved half
  endtask

  // Sample on the edge where the handshake completes
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_idx = 0;
    end else if (out_valid && out_ready) begin
      words[word_idx] = out_word;
      if (word_idx == trace_cfg_pkg::words_per_rec - 1) begin
        match_record();
        word_idx = 0;
      end else begin
        word_idx++;
      end
    end
  end

endmodule

// ==== tests/pipe_trace_assertions.sv ====
// Protocol assertions for trace unit credit use and output stream stability
`timescale 1ns/1ps

module pipe_trace_assertions (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             push,
  input logic                             credit,
  input logic                             out_valid,
  input logic                             out_ready,
  input logic [trace_cfg_pkg::data_w-1:0] out_word
);

  logic [trace_cfg_pkg::credit_w-1:0] credits;  // Credits the producer holds
  int                                 fail_cnt = 0;  // Assertion failures seen

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= trace_cfg_pkg::credit_w'(trace_cfg_pkg::fifo_depth);
    end else begin
      case ({push, credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  ////////////////////////////////////////
  // Credit rules
  ////////////////////////////////////////
  push_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (credits != '0))
    else begin
      $error("push issued with no credit left");
      fail_cnt++;
    end

  credits_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= trace_cfg_pkg::credit_w'(trace_cfg_pkg::fifo_depth))
    else begin
      $error("credit count above buffer depth");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // Stream rule
  ////////////////////////////////////////
  word_held: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_word)))
    else begin
      $error("out_word changed or valid dropped while stalled by out_ready");
      fail_cnt++;
    end

endmodule

bind pipe_trace_top pipe_trace_assertions assert_i (
  .clk, .rst_n, .push, .credit, .out_valid, .out_ready, .out_word
);

// ==== rtl/pipe_trace_top.sv ====
// Pipeline trace unit top level wiring capture, record buffer and word serializer together
`timescale 1ns/1ps

module pipe_trace_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               issue,        // Offer a new instruction
  input  logic [trace_cfg_pkg::data_w-1:0]   issue_pc,
  input  logic [trace_cfg_pkg::data_w-1:0]   issue_instr,
  input  logic                               stall,        // Holds fetch and decode
  input  logic [trace_cfg_pkg::data_w-1:0]   ex_result,
  input  logic [trace_cfg_pkg::data_w-1:0]   mem_addr,
  input  logic [trace_cfg_pkg::data_w-1:0]   wb_value,
  input  logic                               out_ready,
  output logic                               out_valid,
  output logic [trace_cfg_pkg::data_w-1:0]   out_word,
  output logic [trace_cfg_pkg::drop_w-1:0]   dropped_count
);

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////
  logic                        push;       // Capture to buffer
  logic                        credit;     // Buffer back to capture
  logic                        pop;        // Serializer to buffer
  logic                        not_empty;
  trace_types_pkg::trace_rec_t push_rec;
  trace_types_pkg::trace_rec_t head_rec;

  trace_capture capture_i (
    .clk, .rst_n, .issue, .stall, .issue_pc, .issue_instr,
    .ex_result, .mem_addr, .wb_value,
    .push, .rec(push_rec), .credit, .dropped_count
  );

  trace_fifo fifo_i (
    .clk, .rst_n, .push, .rec(push_rec),
    .pop, .not_empty, .head(head_rec), .credit
  );

  trace_serializer ser_i (
    .clk, .rst_n, .not_empty, .head(head_rec), .pop,
    .out_valid, .out_word, .out_ready
  );

endmodule

// ==== rtl/trace_serializer.sv ====
// Trace serializer that streams each buffered record as six 32-bit words with valid/ready
`timescale 1ns/1ps

module trace_serializer (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               not_empty,
  input  trace_types_pkg::trace_rec_t        head,
  output logic                               pop,
  output logic                               out_valid,
  output logic [trace_cfg_pkg::data_w-1:0]   out_word,
  input  logic                               out_ready
);

  trace_types_pkg::trace_rec_t            rec_q;     // Record being sent
  logic [trace_cfg_pkg::word_idx_w-1:0]   word_idx;  // Position within record
  logic                                   last_xfer; // Final word accepted this cycle

  assign last_xfer = out_valid && out_ready &&
                     (word_idx == trace_cfg_pkg::word_idx_w'(trace_cfg_pkg::words_per_rec - 1));

  // Start when idle, or back to back on the final handshake
  assign pop = not_empty && (!out_valid || last_xfer);

  ////////////////////////////////////////
  // Word sequencing
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      word_idx  <= '0;
    end else if (pop) begin
      out_valid <= 1'b1;                 // First word next cycle
      word_idx  <= '0;
    end else if (last_xfer) begin
      out_valid <= 1'b0;                 // Nothing queued, go idle
      word_idx  <= '0;
    end else if (out_valid && out_ready) begin
      word_idx  <= word_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop)
      rec_q <= head;   // Held for the whole record so words stay stable under back-pressure
  end

  ////////////////////////////////////////
  // Output word select
  ////////////////////////////////////////
  always_comb begin
    case (word_idx)
      3'd0:    out_word = rec_q.pc;
      3'd1:    out_word = rec_q.instr;
      3'd2:    out_word = rec_q.ex_result;
      3'd3:    out_word = rec_q.mem_addr;
      3'd4:    out_word = rec_q.wb_value;
      default: out_word = trace_cfg_pkg::data_w'({rec_q.stall_cycles, rec_q.seq}); // Upper half 0
    endcase
  end

endmodule

// ==== rtl/trace_fifo.sv ====
// Circular trace record buffer that hands back one credit per popped entry
`timescale 1ns/1ps

module trace_fifo (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        push,
  input  trace_types_pkg::trace_rec_t rec,
  input  logic                        pop,
  output logic                        not_empty,
  output trace_types_pkg::trace_rec_t head,
  output logic                        credit
);

  trace_types_pkg::trace_rec_t mem [trace_cfg_pkg::fifo_depth];  // Record storage

  logic [trace_cfg_pkg::ptr_w-1:0]    wr_ptr;
  logic [trace_cfg_pkg::ptr_w-1:0]    rd_ptr;
  logic [trace_cfg_pkg::credit_w-1:0] count;   // Entries held

  // Step a pointer with wrap at depth
  function automatic logic [trace_cfg_pkg::ptr_w-1:0] next_ptr(
    input logic [trace_cfg_pkg::ptr_w-1:0] p
  );
    return (p == trace_cfg_pkg::ptr_w'(trace_cfg_pkg::fifo_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  ////////////////////////////////////////
  // Storage write
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= rec;   // Credits keep this from overwriting a live entry
  end

  ////////////////////////////////////////
  // Pointers, occupancy and credit return
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit <= pop;          // One pulse on the cycle after each pop
    end
  end

  assign not_empty = (count != '0);  // Registered count gives the one-cycle fill latency
  assign head      = mem[rd_ptr];    // Oldest record

endmodule

// ==== rtl/trace_capture.sv ====
// Trace capture that follows instructions through five stages and pushes records on credit
`timescale 1ns/1ps

module trace_capture (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                issue,
  input  logic                                stall,
  input  logic [trace_cfg_pkg::data_w-1:0]    issue_pc,
  input  logic [trace_cfg_pkg::data_w-1:0]    issue_instr,
  input  logic [trace_cfg_pkg::data_w-1:0]    ex_result,
  input  logic [trace_cfg_pkg::data_w-1:0]    mem_addr,
  input  logic [trace_cfg_pkg::data_w-1:0]    wb_value,
  output logic                                push,
  output trace_types_pkg::trace_rec_t         rec,
  input  logic                                credit,
  output logic [trace_cfg_pkg::drop_w-1:0]    dropped_count
);

  // Slot index is the stage position from 0 for fetch up to 4 for write-back
  trace_types_pkg::stage_e     slot_st  [5];
  trace_types_pkg::trace_rec_t slot_rec [5];   // Partial records

  logic [trace_cfg_pkg::seq_w-1:0]    seq_cnt;     // Next sequence number
  logic [trace_cfg_pkg::credit_w-1:0] credit_cnt;  // Free slots downstream
  logic                               retire;      // Write-back slot ends this cycle

  // Saturating count up
  function automatic logic [trace_cfg_pkg::stall_w-1:0] sat_inc(
    input logic [trace_cfg_pkg::stall_w-1:0] v
  );
    return (&v) ? v : v + 1'b1;
  endfunction

  ////////////////////////////////////////
  // Stage state advance
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 5; i++) begin
        slot_st[i] <= trace_types_pkg::stage_empty;
      end
      seq_cnt <= '0;
    end else begin
      // Back end never holds
      slot_st[4] <= (slot_st[3] == trace_types_pkg::stage_memory) ?
                    trace_types_pkg::stage_writeback : trace_types_pkg::stage_empty;
      slot_st[3] <= (slot_st[2] == trace_types_pkg::stage_execute) ?
                    trace_types_pkg::stage_memory : trace_types_pkg::stage_empty;
      if (stall) begin
        slot_st[2] <= trace_types_pkg::stage_empty;  // Decode held so execute gets a bubble
      end else begin
        slot_st[2] <= (slot_st[1] == trace_types_pkg::stage_decode) ?
                      trace_types_pkg::stage_execute : trace_types_pkg::stage_empty;
        slot_st[1] <= (slot_st[0] == trace_types_pkg::stage_fetch) ?
                      trace_types_pkg::stage_decode : trace_types_pkg::stage_empty;
        slot_st[0] <= issue ? trace_types_pkg::stage_fetch : trace_types_pkg::stage_empty;
        if (issue)
          seq_cnt <= seq_cnt + 1'b1;                 // Accepted and wraps naturally
      end
    end
  end

  ////////////////////////////////////////
  // Record payload
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    slot_rec[4]           <= slot_rec[3];
    slot_rec[4].mem_addr  <= mem_addr;     // Memory cycle ends here
    slot_rec[3]           <= slot_rec[2];
    slot_rec[3].ex_result <= ex_result;    // Execute cycle ends here
    if (stall) begin
      // Front end holds and each front slot is charged one stall edge
      slot_rec[0].stall_cycles <= sat_inc(slot_rec[0].stall_cycles);
      slot_rec[1].stall_cycles <= sat_inc(slot_rec[1].stall_cycles);
    end else begin
      slot_rec[2] <= slot_rec[1];
      slot_rec[1] <= slot_rec[0];
      slot_rec[0] <= '{seq: seq_cnt, pc: issue_pc, instr: issue_instr, default: '0};
    end
  end

  ////////////////////////////////////////
  // Retire, credit and drop accounting
  ////////////////////////////////////////
  assign retire = (slot_st[4] == trace_types_pkg::stage_writeback);
  assign push   = retire && (credit_cnt != '0);  // Only with a credit in hand

  always_comb begin
    rec          = slot_rec[4];
    rec.wb_value = wb_value;                     // Last value lands as the record leaves
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt    <= trace_cfg_pkg::credit_w'(trace_cfg_pkg::fifo_depth);
      dropped_count <= '0;
    end else begin
      case ({push, credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;  // Spend one
        2'b01:   credit_cnt <= credit_cnt + 1'b1;  // Buffer freed one
        default: credit_cnt <= credit_cnt;         // Both or neither
      endcase
      if (retire && credit_cnt == '0)
        dropped_count <= dropped_count + 1'b1;     // Lost for lack of credit
    end
  end

endmodule

// ==== rtl/trace_types_pkg.sv ====
// Pipeline slot state and retired-instruction record types for the trace unit
package trace_types_pkg;

  ////////////////////////////////////////
  // Slot state
  ////////////////////////////////////////
  // One state per stage position where empty marks a bubble or unused slot
  typedef enum logic [2:0] {
    stage_empty,
    stage_fetch,
    stage_decode,
    stage_execute,
    stage_memory,
    stage_writeback
  } stage_e;

  ////////////////////////////////////////
  // Trace record
  ////////////////////////////////////////
  // Filled stage by stage and complete once write-back ends
  typedef struct packed {
    logic [trace_cfg_pkg::seq_w-1:0]   seq;          // Issue order number
    logic [trace_cfg_pkg::data_w-1:0]  pc;           // Captured at issue
    logic [trace_cfg_pkg::data_w-1:0]  instr;        // Captured at issue
    logic [trace_cfg_pkg::data_w-1:0]  ex_result;    // Sampled in execute
    logic [trace_cfg_pkg::data_w-1:0]  mem_addr;     // Sampled in memory
    logic [trace_cfg_pkg::data_w-1:0]  wb_value;     // Sampled in write-back
    logic [trace_cfg_pkg::stall_w-1:0] stall_cycles; // Fetch plus decode hold edges
  } trace_rec_t;

endpackage

// ==== rtl/trace_cfg_pkg.sv ====
// Sizing constants for the trace unit shared by capture, buffer and serializer
package trace_cfg_pkg;

  ////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////
  localparam int data_w  = 32;  // pc, instruction and stage values
  localparam int seq_w   = 8;   // Instruction sequence number, wraps
  localparam int stall_w = 8;   // Saturating stall-cycle count
  localparam int drop_w  = 16;  // Dropped-record counter

  ////////////////////////////////////////
  // Buffering and credit sizing
  ////////////////////////////////////////
  localparam int fifo_depth = 4;                        // Record slots, also initial credits
  localparam int ptr_w      = $clog2(fifo_depth);       // Buffer read/write pointer
  localparam int credit_w   = $clog2(fifo_depth + 1);   // Holds 0..fifo_depth

  ////////////////////////////////////////
  // Output framing
  ////////////////////////////////////////
  localparam int words_per_rec = 6;                     // Words per trace record
  localparam int word_idx_w    = $clog2(words_per_rec); // Serializer word index

endpackage
